// ==== verilog/lsu_params.svh ====
// Width, memory map and exception vector macros for the load/store path, included by RTL and testbench
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data and address widths
`define LSU_DW 32
`define LSU_AW 32

// On-chip word memory depth, 4 KiB mapped
`define LSU_MEM_WORDS 1024

// First unmapped byte address
// Anything at or above it misses the TLB
`define LSU_MAPPED_LIMIT 32'h0000_1000

// Start of the read-only window, which runs up to the mapped limit
`define LSU_RO_BASE 32'h0000_0C00

// Exception vectors, byte addresses
`define LSU_VECT_DW 8
`define LSU_VECT_TLB_MISS 8'h10
`define LSU_VECT_PAGE_FAULT 8'h14
`define LSU_VECT_ALIGN 8'h18

`endif

// ==== verilog/lsu_pkg.sv ====
// Shared access-size and exception types plus result-code helpers for the load/store RTL and testbench
`include "lsu_params.svh"

package lsu_pkg;

   // Access size, same encoding as the execute stage
   typedef enum logic [2:0] {
      size_byte = 3'd1,
      size_half = 3'd2,
      size_word = 3'd3
   } size_e;

   // Exception reported with a result
   typedef enum logic [1:0] {
      exc_none,
      exc_tlb_miss,
      exc_page_fault,
      exc_misalign
   } exc_e;

   // Fault code carried back on the data bus
   typedef enum logic [1:0] {
      dbus_exc_none,
      dbus_exc_tlb_miss,
      dbus_exc_page_fault
   } dbus_exc_e;

   // Vector of an exception as a word target, zero when there is none
   function automatic logic [`LSU_AW-3:0] exc_target(exc_e exc);
      logic [`LSU_VECT_DW-1:0] vect;
      case (exc)
         exc_tlb_miss:   vect = `LSU_VECT_TLB_MISS;
         exc_page_fault: vect = `LSU_VECT_PAGE_FAULT;
         exc_misalign:   vect = `LSU_VECT_ALIGN;
         default:        vect = '0;
      endcase
      return {{(`LSU_AW - `LSU_VECT_DW){1'b0}}, vect[`LSU_VECT_DW-1:2]};
   endfunction

   // Bus fault to result exception
   function automatic exc_e dbus_to_exc(dbus_exc_e fault);
      case (fault)
         dbus_exc_tlb_miss:   return exc_tlb_miss;
         dbus_exc_page_fault: return exc_page_fault;
         default:             return exc_none;
      endcase
   endfunction

endpackage

// ==== verilog/dbus_if.sv ====
// Data-bus command and response channel between memory unit, protection check and bus master
`timescale 1ns/1ns
`include "lsu_params.svh"

interface dbus_if;

   // Command, held stable by the requester until cmd_ready
   logic                    cmd_valid;
   logic                    cmd_ready;
   logic [`LSU_AW-1:0]      cmd_addr;
   logic                    cmd_we;
   logic [`LSU_DW/8-1:0]    cmd_sel;
   logic [`LSU_DW-1:0]      cmd_wdata;

   // Response, one per accepted command, held until rsp_ready
   logic                    rsp_valid;
   logic                    rsp_ready;
   logic [`LSU_DW-1:0]      rsp_rdata;
   lsu_pkg::dbus_exc_e      rsp_fault;

   modport requester (
      output cmd_valid, cmd_addr, cmd_we, cmd_sel, cmd_wdata,
      input  cmd_ready,
      input  rsp_valid, rsp_rdata, rsp_fault,
      output rsp_ready
   );

   modport responder (
      input  cmd_valid, cmd_addr, cmd_we, cmd_sel, cmd_wdata,
      output cmd_ready,
      output rsp_valid, rsp_rdata, rsp_fault,
      input  rsp_ready
   );

endinterface

// ==== verilog/wb_sram.sv ====
// Wishbone classic slave word memory with byte selects, one-cycle acknowledge
`timescale 1ns/1ns
`include "lsu_params.svh"

module wb_sram (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [`LSU_AW-3:0]    wb_adr,
   input  logic [`LSU_DW/8-1:0]  wb_sel,
   input  logic [`LSU_DW-1:0]    wb_dat_w,
   output logic [`LSU_DW-1:0]    wb_dat_r,
   output logic                  wb_ack
);

   localparam int idx_w = $clog2(`LSU_MEM_WORDS);

   logic [`LSU_DW-1:0]  mem [`LSU_MEM_WORDS];
   logic [idx_w-1:0]    idx;
   logic                in_range;
   logic                access;

   assign idx      = wb_adr[idx_w-1:0];
   // Words past the array read zero and ignore writes
   assign in_range = ~|wb_adr[`LSU_AW-3:idx_w];
   // New strobe seen, not yet acknowledged
   assign access   = wb_cyc & wb_stb & ~wb_ack;

   // One acknowledge per cycle, low again once stb drops
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= access;
      end
   end

   // Write commits and read data appear on the ack edge
   always_ff @(posedge clk) begin
      if (access) begin
         if (wb_we && in_range) begin
            for (int i = 0; i < `LSU_DW/8; i++) begin
               if (wb_sel[i]) begin
                  mem[idx][8*i +: 8] <= wb_dat_w[8*i +: 8];
               end
            end
         end
         wb_dat_r <= in_range ? mem[idx] : '0;
      end
   end

endmodule

// ==== verilog/dbus_wb_master.sv ====
// Bus master that runs one Wishbone classic cycle per data-bus command and holds its response
`timescale 1ns/1ns
`include "lsu_params.svh"

module dbus_wb_master (
   input  logic                  clk,
   input  logic                  arst_n,
   // Data bus from the protection check
   dbus_if.responder             bus,
   // Wishbone classic master side
   output logic                  wb_cyc,
   output logic                  wb_stb,
   output logic                  wb_we,
   output logic [`LSU_AW-3:0]    wb_adr,
   output logic [`LSU_DW/8-1:0]  wb_sel,
   output logic [`LSU_DW-1:0]    wb_dat_w,
   input  logic [`LSU_DW-1:0]    wb_dat_r,
   input  logic                  wb_ack
);

   typedef enum logic [1:0] {st_idle, st_cycle, st_respond} state_e;

   state_e                state;
   logic [`LSU_AW-3:0]    adr_r;
   logic                  we_r;
   logic [`LSU_DW/8-1:0]  sel_r;
   logic [`LSU_DW-1:0]    dat_w_r;
   logic [`LSU_DW-1:0]    rdata_r;

   // Takes a command only when no response is waiting
   assign bus.cmd_ready = (state == st_idle);

   assign wb_cyc   = (state == st_cycle);
   assign wb_stb   = (state == st_cycle);
   assign wb_we    = we_r;
   assign wb_adr   = adr_r;
   assign wb_sel   = sel_r;
   assign wb_dat_w = dat_w_r;

   // No faults from the memory side
   assign bus.rsp_valid = (state == st_respond);
   assign bus.rsp_rdata = rdata_r;
   assign bus.rsp_fault = lsu_pkg::dbus_exc_none;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (bus.cmd_valid) begin
                  state <= st_cycle;
               end
            end
            st_cycle: begin
               // cyc and stb drop on the ack edge
               if (wb_ack) begin
                  state <= st_respond;
               end
            end
            default: begin
               if (bus.rsp_ready) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   // Command and read data capture
   always_ff @(posedge clk) begin
      if (state == st_idle && bus.cmd_valid) begin
         adr_r   <= bus.cmd_addr[`LSU_AW-1:2];
         we_r    <= bus.cmd_we;
         sel_r   <= bus.cmd_sel;
         dat_w_r <= bus.cmd_wdata;
      end
      if (state == st_cycle && wb_ack) begin
         rdata_r <= wb_dat_r;
      end
   end

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
      wb_stb |-> wb_cyc);

endmodule

// ==== verilog/dmmu_check.sv ====
// Data-side protection check that forwards legal commands and answers out-of-window accesses with a fault
`timescale 1ns/1ns
`include "lsu_params.svh"

module dmmu_check (
   input  logic       clk,
   input  logic       arst_n,
   // From the memory unit
   dbus_if.responder  up,
   // Towards the bus master
   dbus_if.requester  down
);

   logic                tlb_miss;
   logic                page_fault;
   logic                illegal;
   logic                flt_valid;
   lsu_pkg::dbus_exc_e  flt_code;

   // Window checks on the command address
   assign tlb_miss   = up.cmd_addr >= `LSU_MAPPED_LIMIT;
   assign page_fault = up.cmd_we & (up.cmd_addr >= `LSU_RO_BASE) &
                       (up.cmd_addr < `LSU_MAPPED_LIMIT);
   assign illegal    = tlb_miss | page_fault;

   // Legal commands go straight through
   assign down.cmd_valid = up.cmd_valid & ~illegal & ~flt_valid;
   assign down.cmd_addr  = up.cmd_addr;
   assign down.cmd_we    = up.cmd_we;
   assign down.cmd_sel   = up.cmd_sel;
   assign down.cmd_wdata = up.cmd_wdata;

   // Illegal commands are taken here while the fault slot is free
   assign up.cmd_ready = ~flt_valid & (illegal | down.cmd_ready);

   // Fault slot wins the response channel
   assign up.rsp_valid  = flt_valid | down.rsp_valid;
   assign up.rsp_rdata  = flt_valid ? '0 : down.rsp_rdata;
   assign up.rsp_fault  = flt_valid ? flt_code : down.rsp_fault;
   assign down.rsp_ready = up.rsp_ready & ~flt_valid;

   // One-entry fault register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flt_valid <= 1'b0;
      end else if (flt_valid) begin
         if (up.rsp_ready) begin
            flt_valid <= 1'b0;
         end
      end else if (up.cmd_valid && illegal) begin
         flt_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!flt_valid && up.cmd_valid && illegal) begin
         flt_code <= tlb_miss ? lsu_pkg::dbus_exc_tlb_miss : lsu_pkg::dbus_exc_page_fault;
      end
   end

   // Fault select must be one-hot
   a_fault_mutex: assert property (@(posedge clk) disable iff (!arst_n)
      up.cmd_valid |-> !(tlb_miss && page_fault));

   // A faulted command never has a downstream response in flight
   a_rsp_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(flt_valid && down.rsp_valid));

endmodule

// ==== verilog/lsu_mu.sv ====
// Memory unit that turns one execute-stage load or store into a data-bus access and a formatted result
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_mu (
   input  logic                  clk,
   input  logic                  arst_n,
   // Operation from execute
   input  logic                  op_valid,
   output logic                  op_ready,
   input  logic                  op_load,
   input  logic                  op_store,
   input  logic                  op_sign_ext,
   input  lsu_pkg::size_e        op_size,
   input  logic [`LSU_AW-1:0]    op_base,
   input  logic [`LSU_AW-1:0]    op_offset,
   input  logic [`LSU_DW-1:0]    op_wdata,
   // Result towards writeback
   output logic                  res_valid,
   input  logic                  res_ready,
   output lsu_pkg::exc_e         res_exc,
   output logic [`LSU_AW-3:0]    res_tgt,
   output logic [`LSU_AW-1:0]    res_lsa,
   output logic [`LSU_DW-1:0]    res_rdata,
   // Data bus
   dbus_if.requester             bus
);

   typedef enum logic {st_idle, st_bus} state_e;

   state_e                state;
   logic                  cmd_pend;
   logic                  op_hs;
   logic                  rsp_hs;
   logic                  res_hs;
   logic [`LSU_AW-1:0]    ea;
   logic                  misalign;
   // Operation captured at the handshake
   logic [`LSU_AW-1:0]    lsa_r;
   lsu_pkg::size_e        size_r;
   logic                  sign_r;
   logic                  store_r;
   logic [`LSU_DW-1:0]    data_r;
   lsu_pkg::exc_e         exc_r;
   logic [`LSU_DW-1:0]    rdata_r;
   // Lane steering
   logic [`LSU_DW/8-1:0]  sel;
   logic [`LSU_DW-1:0]    lanes;
   logic [7:0]            ld_byte;
   logic [15:0]           ld_half;
   logic [`LSU_DW-1:0]    ld_fmt;

   assign op_hs  = op_valid & op_ready;
   assign rsp_hs = bus.rsp_valid & bus.rsp_ready;
   assign res_hs = res_valid & res_ready;

   // Idle and no result waiting
   assign op_ready = (state == st_idle) & ~res_valid;

   // Effective address and alignment check on the incoming op
   assign ea = op_base + op_offset;
   assign misalign = ((op_size == lsu_pkg::size_word) & (|ea[1:0])) |
                     ((op_size == lsu_pkg::size_half) & ea[0]);

   // Byte enables and store data by size and address
   always_comb begin
      case (size_r)
         lsu_pkg::size_byte: begin
            sel   = 4'b0001 << lsa_r[1:0];
            lanes = {4{data_r[7:0]}};
         end
         lsu_pkg::size_half: begin
            sel   = lsa_r[1] ? 4'b1100 : 4'b0011;
            lanes = {2{data_r[15:0]}};
         end
         default: begin
            sel   = 4'b1111;
            lanes = data_r;
         end
      endcase
   end

   // Pick the addressed lane from load data and extend it
   always_comb begin
      case (lsa_r[1:0])
         2'd0:    ld_byte = bus.rsp_rdata[7:0];
         2'd1:    ld_byte = bus.rsp_rdata[15:8];
         2'd2:    ld_byte = bus.rsp_rdata[23:16];
         default: ld_byte = bus.rsp_rdata[31:24];
      endcase
      ld_half = lsa_r[1] ? bus.rsp_rdata[31:16] : bus.rsp_rdata[15:0];
      case (size_r)
         lsu_pkg::size_byte: ld_fmt = {{24{sign_r & ld_byte[7]}}, ld_byte};
         lsu_pkg::size_half: ld_fmt = {{16{sign_r & ld_half[15]}}, ld_half};
         default:            ld_fmt = bus.rsp_rdata;
      endcase
   end

   // Pending FSM and result valid
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= st_idle;
         cmd_pend  <= 1'b0;
         res_valid <= 1'b0;
         exc_r     <= lsu_pkg::exc_none;
      end else begin
         if (res_hs) begin
            res_valid <= 1'b0;
         end
         if (op_hs) begin
            if (misalign) begin
               // Answered at once, no bus access
               res_valid <= 1'b1;
               exc_r     <= lsu_pkg::exc_misalign;
            end else begin
               state    <= st_bus;
               cmd_pend <= 1'b1;
            end
         end
         if (bus.cmd_valid && bus.cmd_ready) begin
            cmd_pend <= 1'b0;
         end
         if (rsp_hs) begin
            state     <= st_idle;
            res_valid <= 1'b1;
            exc_r     <= lsu_pkg::dbus_to_exc(bus.rsp_fault);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (op_hs) begin
         lsa_r   <= ea;
         size_r  <= op_size;
         sign_r  <= op_sign_ext;
         store_r <= op_store;
         data_r  <= op_wdata;
      end
      if (op_hs && misalign) begin
         rdata_r <= '0;
      end
      // Load data only for a fault-free load
      if (rsp_hs) begin
         rdata_r <= (store_r || (bus.rsp_fault != lsu_pkg::dbus_exc_none)) ? '0 : ld_fmt;
      end
   end

   // Command from the captured op, stable for the whole access
   assign bus.cmd_valid = cmd_pend;
   assign bus.cmd_addr  = {lsa_r[`LSU_AW-1:2], 2'b00};
   assign bus.cmd_we    = store_r;
   assign bus.cmd_sel   = sel;
   assign bus.cmd_wdata = lanes;
   assign bus.rsp_ready = (state == st_bus) & ~cmd_pend;

   assign res_exc   = exc_r;
   assign res_tgt   = lsu_pkg::exc_target(exc_r);
   assign res_lsa   = lsa_r;
   assign res_rdata = rdata_r;

   a_op_dir: assert property (@(posedge clk) disable iff (!arst_n)
      op_hs |-> !(op_load && op_store));

   // Command held until the downstream side takes it
   a_cmd_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (bus.cmd_valid && !bus.cmd_ready) |=>
      (bus.cmd_valid && $stable({bus.cmd_addr, bus.cmd_we, bus.cmd_sel, bus.cmd_wdata})));

endmodule

// ==== verilog/lsu_top.sv ====
// Top level of the load/store path: memory unit, protection check, Wishbone master and word memory
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_top (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  op_valid,
   output logic                  op_ready,
   input  logic                  op_load,
   input  logic                  op_store,
   input  logic                  op_sign_ext,
   input  lsu_pkg::size_e        op_size,
   input  logic [`LSU_AW-1:0]    op_base,
   input  logic [`LSU_AW-1:0]    op_offset,
   input  logic [`LSU_DW-1:0]    op_wdata,
   output logic                  res_valid,
   input  logic                  res_ready,
   output lsu_pkg::exc_e         res_exc,
   output logic [`LSU_AW-3:0]    res_tgt,
   output logic [`LSU_AW-1:0]    res_lsa,
   output logic [`LSU_DW-1:0]    res_rdata
);

   // Wishbone between master and memory
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   logic [`LSU_AW-3:0]    wb_adr;
   logic [`LSU_DW/8-1:0]  wb_sel;
   logic [`LSU_DW-1:0]    wb_dat_w;
   logic [`LSU_DW-1:0]    wb_dat_r;
   logic                  wb_ack;

   // Memory unit to check, check to master
   dbus_if mu_bus ();
   dbus_if mem_bus ();

   lsu_mu u_mu (
      .clk         (clk),
      .arst_n      (arst_n),
      .op_valid    (op_valid),
      .op_ready    (op_ready),
      .op_load     (op_load),
      .op_store    (op_store),
      .op_sign_ext (op_sign_ext),
      .op_size     (op_size),
      .op_base     (op_base),
      .op_offset   (op_offset),
      .op_wdata    (op_wdata),
      .res_valid   (res_valid),
      .res_ready   (res_ready),
      .res_exc     (res_exc),
      .res_tgt     (res_tgt),
      .res_lsa     (res_lsa),
      .res_rdata   (res_rdata),
      .bus         (mu_bus)
   );

   dmmu_check u_dmmu (
      .clk    (clk),
      .arst_n (arst_n),
      .up     (mu_bus),
      .down   (mem_bus)
   );

   dbus_wb_master u_wbm (
      .clk      (clk),
      .arst_n   (arst_n),
      .bus      (mem_bus),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_sel   (wb_sel),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   wb_sram u_sram (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_sel   (wb_sel),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

endmodule

// ==== tb/lsu_tb_ref.svh ====
// Reference model for the load/store testbench, a shadow memory and the expected results, included in lsu_tb
`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

// Shadow of the word memory, one known flag per byte
logic [`LSU_DW-1:0]  shadow [`LSU_MEM_WORDS];
logic [3:0]          known [`LSU_MEM_WORDS];

// Byte lanes covered by an access of this size at this byte offset
function automatic logic [3:0] lane_mask(lsu_pkg::size_e size, logic [1:0] off);
   case (size)
      lsu_pkg::size_byte: return 4'b0001 << off;
      lsu_pkg::size_half: return 4'b0011 << off;
      default:            return 4'b1111;
   endcase
endfunction

// Expected outcome of one op, a legal store also updates the shadow
function automatic void expect_result(
   input  logic store, input lsu_pkg::size_e size, input logic sext,
   input  logic [`LSU_AW-1:0] base, input logic [`LSU_AW-1:0] off,
   input  logic [`LSU_DW-1:0] wdata,
   output lsu_pkg::exc_e exc, output logic [`LSU_AW-3:0] tgt,
   output logic [`LSU_AW-1:0] lsa, output logic [`LSU_DW-1:0] rdata,
   output logic rknown);
   logic [3:0]                         mask;
   logic [$clog2(`LSU_MEM_WORDS)-1:0]  idx;
   logic [`LSU_DW-1:0]                 wr;
   logic [`LSU_DW-1:0]                 lane;
   logic [`LSU_VECT_DW-1:0]            vect;
   lsa    = base + off;
   mask   = lane_mask(size, lsa[1:0]);
   idx    = lsa[$clog2(`LSU_MEM_WORDS)+1:2];
   rdata  = '0;
   rknown = 1'b1;
   // Alignment first, then the mapped limit, then the read-only window
   if ((size == lsu_pkg::size_half && lsa[0]) ||
       (size == lsu_pkg::size_word && lsa[1:0] != 2'b00)) begin
      exc  = lsu_pkg::exc_misalign;
      vect = `LSU_VECT_ALIGN;
   end else if (lsa >= `LSU_MAPPED_LIMIT) begin
      exc  = lsu_pkg::exc_tlb_miss;
      vect = `LSU_VECT_TLB_MISS;
   end else if (store && lsa >= `LSU_RO_BASE) begin
      exc  = lsu_pkg::exc_page_fault;
      vect = `LSU_VECT_PAGE_FAULT;
   end else begin
      exc  = lsu_pkg::exc_none;
      vect = '0;
   end
   // Vector as a word target
   tgt = '0;
   tgt[`LSU_VECT_DW-3:0] = vect[`LSU_VECT_DW-1:2];
   if (exc == lsu_pkg::exc_none && store) begin
      // Store data shifted up to its lane
      wr = wdata << (8 * lsa[1:0]);
      for (int i = 0; i < 4; i++) begin
         if (mask[i]) begin
            shadow[idx][8*i +: 8] = wr[8*i +: 8];
         end
      end
      known[idx] = known[idx] | mask;
   end else if (exc == lsu_pkg::exc_none) begin
      rknown = ((known[idx] & mask) == mask);
      lane   = shadow[idx] >> (8 * lsa[1:0]);
      case (size)
         lsu_pkg::size_byte: rdata = sext ? {{24{lane[7]}}, lane[7:0]} : {24'b0, lane[7:0]};
         lsu_pkg::size_half: rdata = sext ? {{16{lane[15]}}, lane[15:0]} : {16'b0, lane[15:0]};
         default:            rdata = lane;
      endcase
   end
endfunction

`endif

// ==== tb/lsu_tb.sv ====
// Self-checking testbench for the load/store path, drives ops on the falling clock edge
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_tb;

   localparam int period = 100;
   localparam int n_rand = 16;
   // Two random phases plus the directed lane, misalign and fault ops
   localparam int n_ops  = 5 * n_rand + 44;
   localparam int res_w  = 2 + (`LSU_AW - 2) + `LSU_AW + `LSU_DW;

   logic                  clk = 1'b0;
   logic                  arst_n;
   logic                  op_valid;
   logic                  op_ready;
   logic                  op_load;
   logic                  op_store;
   logic                  op_sign_ext;
   lsu_pkg::size_e        op_size;
   logic [`LSU_AW-1:0]    op_base;
   logic [`LSU_AW-1:0]    op_offset;
   logic [`LSU_DW-1:0]    op_wdata;
   logic                  res_valid;
   logic                  res_ready;
   lsu_pkg::exc_e         res_exc;
   logic [`LSU_AW-3:0]    res_tgt;
   logic [`LSU_AW-1:0]    res_lsa;
   logic [`LSU_DW-1:0]    res_rdata;
   integer                seed = 95;
   integer                ready_seed;
   logic                  bp_en;
   logic                  held = 1'b0;
   logic [res_w-1:0]      held_res;

   // Expected results, oldest first
   lsu_pkg::exc_e         exp_exc [$];
   logic [`LSU_AW-3:0]    exp_tgt [$];
   logic [`LSU_AW-1:0]    exp_lsa [$];
   logic [`LSU_DW-1:0]    exp_rdata [$];
   logic                  exp_known [$];
   string                 exp_name [$];

   `include "lsu_tb_ref.svh"

   lsu_top UUT (.*);

   always #(period / 2) clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_exc(input string name, input lsu_pkg::exc_e exp, input lsu_pkg::exc_e act);
      if (act !== exp) begin
         stop_on_error($sformatf("[ERROR] %s res_exc: expected %s, actual %s",
                                 name, exp.name(), act.name()));
      end
   endtask

   task automatic check_word(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         stop_on_error($sformatf("[ERROR] %s %s: expected %h, actual %h", name, field, exp, act));
      end
   endtask

   // One op with a random base and offset split, entered and left on a falling edge
   task automatic run_op(input string name, input logic store, input lsu_pkg::size_e size,
                         input logic sext, input logic [`LSU_AW-1:0] addr,
                         input logic [`LSU_DW-1:0] wdata);
      lsu_pkg::exc_e       exc;
      logic [`LSU_AW-3:0]  tgt;
      logic [`LSU_AW-1:0]  lsa;
      logic [`LSU_DW-1:0]  rdata;
      logic [`LSU_AW-1:0]  off;
      logic                rknown;
      off         = $unsigned($random(seed)) & 32'h0000_00FF;
      op_valid    = 1'b1;
      op_load     = !store;
      op_store    = store;
      op_sign_ext = sext;
      op_size     = size;
      op_base     = addr - off;
      op_offset   = off;
      op_wdata    = wdata;
      // op_ready holds until the next rising edge, which is the handshake
      while (!op_ready) begin
         @(negedge clk);
      end
      expect_result(store, size, sext, op_base, op_offset, wdata, exc, tgt, lsa, rdata, rknown);
      exp_exc.push_back(exc);
      exp_tgt.push_back(tgt);
      exp_lsa.push_back(lsa);
      exp_rdata.push_back(rdata);
      exp_known.push_back(rknown);
      exp_name.push_back(name);
      @(negedge clk);
      op_valid = 1'b0;
      // Misaligned result is due in the cycle right after the handshake
      if (exc == lsu_pkg::exc_misalign && !res_valid) begin
         stop_on_error($sformatf("%s: misaligned op gave no result one cycle after handshake", name));
      end
   endtask

   // Result comparison at every rising edge
   always @(posedge clk) begin
      if (arst_n) begin
         if (held && !res_valid) begin
            stop_on_error("result withdrawn while res_ready was low");
         end
         if (res_valid) begin
            if (op_ready) begin
               stop_on_error("op_ready high while a result is waiting");
            end
            if (held && {res_exc, res_tgt, res_lsa, res_rdata} !== held_res) begin
               stop_on_error("result changed while res_ready was low");
            end
            if (res_ready) begin
               if (exp_exc.size() == 0) begin
                  stop_on_error("result arrived with no operation outstanding");
               end
               check_exc(exp_name[0], exp_exc[0], res_exc);
               check_word(exp_name[0], "res_tgt", {2'b00, exp_tgt[0]}, {2'b00, res_tgt});
               check_word(exp_name[0], "res_lsa", exp_lsa[0], res_lsa);
               if (exp_known[0]) begin
                  check_word(exp_name[0], "res_rdata", exp_rdata[0], res_rdata);
               end
               void'(exp_exc.pop_front());
               void'(exp_tgt.pop_front());
               void'(exp_lsa.pop_front());
               void'(exp_rdata.pop_front());
               void'(exp_known.pop_front());
               void'(exp_name.pop_front());
            end
         end
         held     = res_valid & ~res_ready;
         held_res = {res_exc, res_tgt, res_lsa, res_rdata};
      end
   end

   // Result back-pressure, ready about one edge in four when enabled
   initial begin
      ready_seed = ~seed;
      res_ready  = 1'b1;
      forever begin
         @(negedge clk);
         res_ready = !bp_en || (($random(ready_seed) & 3) == 0);
      end
   end

   // Watchdog sized from the op count
   initial begin
      #(period * (4 + 40 * n_ops));
      stop_on_error($sformatf("Run timed out after %0d cycles without finishing", 40 * n_ops));
   end

   initial begin
      logic [`LSU_AW-1:0]  a;
      logic [`LSU_DW-1:0]  pat;
      arst_n      = 1'b0;
      op_valid    = 1'b0;
      op_load     = 1'b0;
      op_store    = 1'b0;
      op_sign_ext = 1'b0;
      op_size     = lsu_pkg::size_word;
      op_base     = '0;
      op_offset   = '0;
      op_wdata    = '0;
      bp_en       = 1'b0;
      for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
         known[i] = 4'b0000;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      if (!op_ready || res_valid) begin
         stop_on_error("op_ready low or res_valid high after reset");
      end

      // Word store and load back below the read-only window
      repeat (n_rand) begin
         a   = ($unsigned($random(seed)) % (`LSU_RO_BASE / 4)) << 2;
         pat = $random(seed);
         run_op("word_rw", 1'b1, lsu_pkg::size_word, 1'b0, a, pat);
         run_op("word_rw", 1'b0, lsu_pkg::size_word, 1'b0, a, '0);
      end

      // Byte into each lane of a known word
      for (int l = 0; l < 4; l++) begin
         pat = $random(seed);
         run_op("byte_lane", 1'b1, lsu_pkg::size_word, 1'b0, 32'h100, pat);
         pat = $random(seed);
         run_op("byte_lane", 1'b1, lsu_pkg::size_byte, 1'b0, 32'h100 + l, pat);
         run_op("byte_lane", 1'b0, lsu_pkg::size_word, 1'b0, 32'h100, '0);
         run_op("byte_lane", 1'b0, lsu_pkg::size_byte, 1'b0, 32'h100 + l, '0);
         run_op("byte_lane", 1'b0, lsu_pkg::size_byte, 1'b1, 32'h100 + l, '0);
      end
      // Lower and upper halfword
      for (int h = 0; h < 2; h++) begin
         pat = $random(seed);
         run_op("half_lane", 1'b1, lsu_pkg::size_word, 1'b0, 32'h104, pat);
         pat = $random(seed);
         run_op("half_lane", 1'b1, lsu_pkg::size_half, 1'b0, 32'h104 + 2 * h, pat);
         run_op("half_lane", 1'b0, lsu_pkg::size_word, 1'b0, 32'h104, '0);
         run_op("half_lane", 1'b0, lsu_pkg::size_half, 1'b0, 32'h104 + 2 * h, '0);
         run_op("half_lane", 1'b0, lsu_pkg::size_half, 1'b1, 32'h104 + 2 * h, '0);
      end

      // Misaligned stores must leave the word alone
      run_op("misalign", 1'b1, lsu_pkg::size_word, 1'b0, 32'h200, 32'hCAFE_F00D);
      run_op("misalign", 1'b1, lsu_pkg::size_half, 1'b0, 32'h201, 32'h1111_1111);
      run_op("misalign", 1'b1, lsu_pkg::size_word, 1'b0, 32'h202, 32'h2222_2222);
      run_op("misalign", 1'b0, lsu_pkg::size_word, 1'b0, 32'h203, '0);
      run_op("misalign", 1'b0, lsu_pkg::size_word, 1'b0, 32'h200, '0);

      // Unmapped space and the read-only window
      run_op("tlb_miss", 1'b1, lsu_pkg::size_word, 1'b0, `LSU_MAPPED_LIMIT, 32'h1234_5678);
      run_op("tlb_miss", 1'b0, lsu_pkg::size_byte, 1'b0, 32'h8000_0001, '0);
      run_op("tlb_miss", 1'b0, lsu_pkg::size_word, 1'b0, 32'hFFFF_FFFC, '0);
      run_op("page_fault", 1'b1, lsu_pkg::size_byte, 1'b0, `LSU_RO_BASE + 5, 32'h0000_00A5);
      run_op("page_fault", 1'b1, lsu_pkg::size_word, 1'b0, `LSU_MAPPED_LIMIT - 4, 32'h5A5A_5A5A);
      run_op("ro_load", 1'b0, lsu_pkg::size_word, 1'b0, `LSU_RO_BASE + 8, '0);
      run_op("ro_load", 1'b0, lsu_pkg::size_half, 1'b1, `LSU_MAPPED_LIMIT - 2, '0);
      pat = $random(seed);
      run_op("rw_edge", 1'b1, lsu_pkg::size_word, 1'b0, `LSU_RO_BASE - 4, pat);
      run_op("rw_edge", 1'b0, lsu_pkg::size_word, 1'b0, `LSU_RO_BASE - 4, '0);

      // Same traffic with res_ready dropping at random
      @(posedge clk);
      bp_en = 1'b1;
      @(negedge clk);
      repeat (n_rand) begin
         a   = ($unsigned($random(seed)) % (`LSU_RO_BASE / 4)) << 2;
         pat = $random(seed);
         run_op("backpressure", 1'b1, lsu_pkg::size_word, 1'b0, a, pat);
         run_op("backpressure", 1'b0, lsu_pkg::size_byte, 1'b1,
                a + ($unsigned($random(seed)) & 3), '0);
         run_op("backpressure", 1'b0, lsu_pkg::size_half, 1'b0, a + 1, '0);
      end

      // Drain the last result
      while (exp_exc.size() != 0) begin
         @(negedge clk);
      end
      @(negedge clk);
      $display("Verification passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+verilog
+incdir+tb
verilog/lsu_pkg.sv
verilog/dbus_if.sv
verilog/wb_sram.sv
verilog/dbus_wb_master.sv
verilog/dmmu_check.sv
verilog/lsu_mu.sv
verilog/lsu_top.sv
tb/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the load/store testbench with Verilator, runs it into a log and reports the outcome

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ns --top-module lsu_tb \
   -f verilog.f -o Vlsu_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vlsu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
   echo "Simulation FAILED, see $LOG"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status, see $LOG"
   exit 1
fi

echo "Simulation PASSED"
exit 0
